// File: compile.f
+incdir+.
lapido_pkg.sv
if_stage.sv
id_stage.sv
register_file.sv
hazard_unit.sv
ex_stage.sv
mem_stage.sv
lapido_top.sv
lapido_assert.sv
lapido_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module lapido_tb -o lapido_sim \
    && ./obj_dir/lapido_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: lapido_ref_model.svh
`ifndef LAPIDO_REF_MODEL_SVH
`define LAPIDO_REF_MODEL_SVH

// Instruction encoders and program builder
function automatic logic [31:0] r_type(input opcode_e op, input int rd,
                                       input int rs, input int rt);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'd0};
endfunction

function automatic logic [31:0] i_type(input opcode_e op, input int rt,
                                       input int rs, input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] j_type(input int off);
    return {OP_J, 26'(off)};  // Offset in words from pc plus four
endfunction

task automatic emit(input logic [31:0] instr);
    imem[prog_start + prog_len] = instr;
    prog_len++;
endtask

// Instruction-level model that runs one instruction per step
function automatic void predict_stores();
    logic [31:0] r [32];
    logic [31:0] rmem [int];
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] sext;
    logic [31:0] addr;
    logic [31:0] nxt;
    logic [5:0]  opc;
    int          rs;
    int          rt;
    int          rd;
    int          steps;
    exp_q.delete();
    for (int i = 0; i < 32; i++) r[i] = '0;
    pc    = RESET_PC;
    steps = 0;
    while (steps < 1000) begin
        instr = imem[pc[9:2]];
        opc   = instr[31:26];
        rs    = int'(instr[25:21]);
        rt    = int'(instr[20:16]);
        rd    = int'(instr[15:11]);
        sext  = {{16{instr[15]}}, instr[15:0]};
        addr  = r[rs] + sext;
        nxt   = pc + 32'd4;
        steps++;
        if (opc == OP_HALT) break;
        case (opc)
            OP_ADD:  if (rd != 0) r[rd] = r[rs] + r[rt];
            OP_SUB:  if (rd != 0) r[rd] = r[rs] - r[rt];
            OP_AND:  if (rd != 0) r[rd] = r[rs] & r[rt];
            OP_OR:   if (rd != 0) r[rd] = r[rs] | r[rt];
            OP_XOR:  if (rd != 0) r[rd] = r[rs] ^ r[rt];
            OP_SLT:  if (rd != 0) r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
            OP_ADDI: if (rt != 0) r[rt] = addr;
            OP_LUI:  if (rt != 0) r[rt] = {instr[15:0], 16'd0};
            OP_LW: begin
                if (rt != 0) begin
                    r[rt] = rmem.exists(int'(addr[9:2])) ? rmem[int'(addr[9:2])]
                                                       : fill_word({22'd0, addr[9:2], 2'b00});
                end
            end
            OP_SW: begin
                rmem[int'(addr[9:2])] = r[rt];
                exp_q.push_back({addr, r[rt]});
            end
            OP_BEQ:  if (r[rs] == r[rt]) nxt = pc + 32'd4 + {sext[29:0], 2'b00};
            OP_BNE:  if (r[rs] != r[rt]) nxt = pc + 32'd4 + {sext[29:0], 2'b00};
            OP_J:    nxt = pc + 32'd4 + {{4{instr[25]}}, instr[25:0], 2'b00};
            default: ;  // Unused codes act as NOP
        endcase
        pc = nxt;
    end
endfunction

`endif

// File: lapido_tb.sv
`default_nettype none

module lapido_tb;
    import lapido_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int prog_start = 64;  // RESET_PC as a word index

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        halted;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [63:0] obs_q [$];  // {addr, data} per store
    logic [63:0] exp_q [$];
    int          prog_len;
    int          checks;
    int          errors;
    int          tests;
    int          budget = 50;
    int          cycle_count;
    int          seed = 32'h1606_8ee8;
    string       test_name;
    event        run_done;
    event        cmp_done;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    `include "lapido_ref_model.svh"

    lapido_top #(.RESET_PC(RESET_PC)) lapido_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (arst_n && dmem_we) begin
            obs_q.push_back({dmem_addr, dmem_wdata});
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog budget grows with each program loaded
    initial begin
        cycle_count = 0;
        while (cycle_count <= budget) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: halted did not rise within %0d cycles", budget);
        $display("Checks failed");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Compares the store lists one entry at a time
    initial begin
        forever begin
            @(run_done);
            check({test_name, " store count"}, 64'(exp_q.size()), 64'(obs_q.size()));
            for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
                check($sformatf("%s store %0d", test_name, i), exp_q[i], obs_q[i]);
            end
            $display("Test %s finished, %0d stores, %0d errors so far", test_name,
                     obs_q.size(), errors);
            ->cmp_done;
        end
    end

    // Entered at time zero or right after a falling edge
    task automatic begin_test(input string name);
        arst_n = 1'b0;
        test_name = name;
        tests++;
        obs_q.delete();
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {OP_HALT, 26'(i * 4)};  // Runaway fetch ends in HALT
            dmem[i] <= fill_word(32'(i * 4));
        end
    endtask

    task automatic run_program();
        predict_stores();
        budget += prog_len * 8 + 20;
        repeat (3) @(negedge clk);
        check({test_name, " reset pc"}, 64'(RESET_PC), 64'(imem_addr));
        arst_n = 1'b1;
        while (halted !== 1'b1) @(negedge clk);
        repeat (6) @(negedge clk);  // Room for any stray store after HALT
        check({test_name, " halted"}, 64'd1, 64'(halted));
        ->run_done;
        @(cmp_done);
    endtask

    initial begin
        logic [31:0] rnd;
        arst_n = 1'b0;
        checks = 0;
        errors = 0;
        tests  = 0;

        begin_test("forwarding");
        emit(i_type(OP_ADDI, 1, 0, 5));
        emit(i_type(OP_ADDI, 2, 1, 7));   // EX/MEM source
        emit(r_type(OP_ADD, 3, 1, 2));    // MEM/WB and EX/MEM
        emit(i_type(OP_SW, 3, 0, 'h200));
        emit(r_type(OP_SUB, 4, 3, 1));
        emit(i_type(OP_SW, 4, 0, 'h204));
        emit(i_type(OP_LUI, 5, 0, 'h1234));
        emit(r_type(OP_OR, 6, 5, 4));
        emit(r_type(OP_XOR, 9, 6, 3));
        emit(i_type(OP_SW, 9, 0, 'h208));
        emit(i_type(OP_ADDI, 7, 0, -3));
        emit(r_type(OP_SLT, 8, 7, 1));
        emit(r_type(OP_AND, 10, 8, 6));
        emit(i_type(OP_SW, 8, 0, 'h20c));
        emit(i_type(OP_SW, 10, 0, 'h210));
        emit({OP_HALT, 26'd0});
        run_program();

        begin_test("load_use");
        emit(i_type(OP_LW, 1, 0, 'h300));
        emit(r_type(OP_ADD, 2, 1, 1));    // Needs the stall
        emit(i_type(OP_SW, 2, 0, 'h304));
        emit(i_type(OP_LW, 3, 0, 'h304));
        emit(i_type(OP_ADDI, 4, 3, 1));
        emit(i_type(OP_SW, 4, 0, 'h308));
        emit({OP_HALT, 26'd0});
        run_program();

        begin_test("branches");
        emit(i_type(OP_ADDI, 1, 0, 3));
        emit(i_type(OP_ADDI, 2, 0, 3));
        emit(i_type(OP_BEQ, 2, 1, 2));    // Taken
        emit(i_type(OP_SW, 1, 0, 'h400));
        emit(i_type(OP_SW, 2, 0, 'h404));
        emit(i_type(OP_SW, 1, 0, 'h408));
        emit(i_type(OP_BNE, 2, 1, 1));    // Not taken
        emit(i_type(OP_SW, 2, 0, 'h40c));
        emit(i_type(OP_BEQ, 0, 1, 1));    // Not taken
        emit(i_type(OP_SW, 1, 0, 'h410));
        emit(i_type(OP_BNE, 0, 1, 2));    // Taken
        emit(i_type(OP_SW, 1, 0, 'h414));
        emit(i_type(OP_SW, 1, 0, 'h418));
        emit(j_type(1));
        emit(i_type(OP_SW, 2, 0, 'h41c));
        emit(i_type(OP_SW, 2, 0, 'h420));
        emit({OP_HALT, 26'd0});
        run_program();

        begin_test("random");
        for (int k = 0; k < 48; k++) begin
            rnd = $random(seed);
            case (int'(rnd[27:24]) % 10)
                0, 1, 2: emit(r_type(opcode_e'(6'd1 + 6'(int'(rnd[23:20]) % 6)),
                                     int'(rnd[10:8]), int'(rnd[13:11]), int'(rnd[7:5])));
                3, 4:    emit(i_type(OP_ADDI, int'(rnd[10:8]), int'(rnd[13:11]),
                                     int'(rnd[31:16])));
                5:       emit(i_type(OP_LUI, int'(rnd[10:8]), 0, int'(rnd[31:16])));
                6, 7:    emit(i_type(OP_LW, int'(rnd[10:8]), 0, 'h500 + 4 * int'(rnd[19:16])));
                default: emit(i_type(OP_SW, int'(rnd[10:8]), 0, 'h500 + 4 * int'(rnd[19:16])));
            endcase
        end
        emit({OP_HALT, 26'd0});
        run_program();

        begin_test("halt");
        emit(i_type(OP_ADDI, 1, 0, 9));
        emit(i_type(OP_SW, 1, 0, 'h600));
        emit({OP_HALT, 26'd0});
        emit(i_type(OP_SW, 1, 0, 'h604));
        emit(i_type(OP_SW, 1, 0, 'h608));
        run_program();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lapido_assert.sv
`default_nettype none

module lapido_assert (
    input logic                        clk,
    input logic                        arst_n,
    input logic [lapido_pkg::xlen-1:0] imem_addr,
    input logic                        dmem_we,
    input logic                        halted
);

    // Outputs quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> (!dmem_we && !halted))
        else $error("dmem_we or halted high during reset");

    halted_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
        else $error("halted fell without reset");

    fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

endmodule

bind lapido_top lapido_assert lapido_assert_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .dmem_we   (dmem_we),
    .halted    (halted)
);

`default_nettype wire

// File: lapido_top.sv
`default_nettype none

module lapido_top #(
    parameter logic [lapido_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    output logic [lapido_pkg::xlen-1:0] imem_addr,
    input  logic [lapido_pkg::xlen-1:0] imem_data,
    output logic [lapido_pkg::xlen-1:0] dmem_addr,
    output logic [lapido_pkg::xlen-1:0] dmem_wdata,
    output logic                        dmem_we,
    input  logic [lapido_pkg::xlen-1:0] dmem_rdata,
    output logic                        halted
);
    import lapido_pkg::*;

    ifid_t                 ifid;
    idex_t                 idex;
    exmem_t                exmem;
    memwb_t                memwb;
    logic                  stall;
    logic                  jump_taken;
    logic [xlen-1:0]       jump_target;
    logic                  branch_taken;
    logic [xlen-1:0]       branch_target;
    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [xlen-1:0]       rs_data;
    logic [xlen-1:0]       rt_data;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic [xlen-1:0]       exmem_fwd;  // Write-back value of EX/MEM

    if_stage #(.RESET_PC(RESET_PC)) if_stage_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt          (idex.ctrl.is_halt),  // HALT just left decode
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .ifid          (ifid)
    );

    id_stage id_stage_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .ifid         (ifid),
        .stall        (stall),
        .branch_taken (branch_taken),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .jump_taken   (jump_taken),
        .jump_target  (jump_target),
        .idex         (idex)
    );

    register_file register_file_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (memwb)
    );

    hazard_unit hazard_unit_inst (
        .ifid  (ifid),
        .idex  (idex),
        .exmem (exmem),
        .memwb (memwb),
        .stall (stall),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b)
    );

    ex_stage ex_stage_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .idex          (idex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .exmem_fwd     (exmem_fwd),
        .memwb_fwd     (memwb.wb_value),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exmem         (exmem)
    );

    mem_stage mem_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .exmem      (exmem),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .exmem_fwd  (exmem_fwd),
        .halted     (halted),
        .memwb      (memwb)
    );

endmodule

`default_nettype wire

// File: mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  lapido_pkg::exmem_t          exmem,
    output logic [lapido_pkg::xlen-1:0] dmem_addr,
    output logic [lapido_pkg::xlen-1:0] dmem_wdata,
    output logic                        dmem_we,
    input  logic [lapido_pkg::xlen-1:0] dmem_rdata,
    output logic [lapido_pkg::xlen-1:0] exmem_fwd,
    output logic                        halted,
    output lapido_pkg::memwb_t          memwb
);
    import lapido_pkg::*;

    logic halt_q;

    assign dmem_addr  = exmem.alu_res;
    assign dmem_wdata = exmem.store_data;
    assign dmem_we    = exmem.ctrl.mem_we;

    // Same value feeds MEM/WB and the EX/MEM forwarding path
    always_comb begin
        case (exmem.ctrl.wb_sel)
            WB_MEM:  exmem_fwd = dmem_rdata;
            WB_IMM:  exmem_fwd = exmem.imm;
            default: exmem_fwd = exmem.alu_res;
        endcase
    end

    assign halted = halt_q | exmem.ctrl.is_halt;  // Rises with HALT in EX/MEM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            memwb  <= '0;
            halt_q <= 1'b0;
        end else begin
            memwb.reg_we   <= exmem.ctrl.reg_we;
            memwb.dest     <= exmem.dest;
            memwb.wb_value <= exmem_fwd;
            if (exmem.ctrl.is_halt) halt_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: ex_stage.sv
`default_nettype none

module ex_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  lapido_pkg::idex_t           idex,
    input  lapido_pkg::fwd_sel_e        fwd_a,
    input  lapido_pkg::fwd_sel_e        fwd_b,
    input  logic [lapido_pkg::xlen-1:0] exmem_fwd,
    input  logic [lapido_pkg::xlen-1:0] memwb_fwd,
    output logic                        branch_taken,
    output logic [lapido_pkg::xlen-1:0] branch_target,
    output lapido_pkg::exmem_t          exmem
);
    import lapido_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;     // rt after forwarding, also the store data
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;
    logic            equal;

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [xlen-1:0] reg_val,
                                                input logic [xlen-1:0] exmem_val,
                                                input logic [xlen-1:0] memwb_val);
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, idex.rs_data, exmem_fwd, memwb_fwd);
    assign op_b  = fwd_mux(fwd_b, idex.rt_data, exmem_fwd, memwb_fwd);
    assign alu_b = idex.ctrl.use_imm ? idex.imm : op_b;

    always_comb begin
        case (idex.ctrl.alu_op)
            OP_ADD:  alu_res = op_a + alu_b;
            OP_SUB:  alu_res = op_a - alu_b;
            OP_AND:  alu_res = op_a & alu_b;
            OP_OR:   alu_res = op_a | alu_b;
            OP_XOR:  alu_res = op_a ^ alu_b;
            OP_SLT:  alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_res = '0;
        endcase
    end

    // BEQ/BNE compare the forwarded registers
    assign equal         = (op_a == op_b);
    assign branch_taken  = idex.ctrl.is_branch && (idex.ctrl.branch_ne ? !equal : equal);
    assign branch_target = idex.pc_plus4 + {idex.imm[xlen-3:0], 2'b00};

    // The branch itself moves on, only the two younger slots are flushed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exmem <= '0;
        end else begin
            exmem.ctrl          <= idex.ctrl;
            exmem.alu_res       <= alu_res;
            exmem.store_data    <= op_b;
            exmem.dest          <= idex.dest;
            exmem.imm           <= idex.imm;
            exmem.branch_target <= branch_target;
        end
    end

endmodule

`default_nettype wire

// File: hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  lapido_pkg::ifid_t    ifid,
    input  lapido_pkg::idex_t    idex,
    input  lapido_pkg::exmem_t   exmem,
    input  lapido_pkg::memwb_t   memwb,
    output logic                 stall,
    output lapido_pkg::fwd_sel_e fwd_a,
    output lapido_pkg::fwd_sel_e fwd_b
);
    import lapido_pkg::*;

    logic [reg_addr_w-1:0] id_rs;
    logic [reg_addr_w-1:0] id_rt;

    // Youngest producer first, r0 never forwards
    function automatic fwd_sel_e pick(input logic [reg_addr_w-1:0] src,
                                      input exmem_t em,
                                      input memwb_t mw);
        if (em.ctrl.reg_we && em.dest != '0 && em.dest == src)  return FWD_EXMEM;
        else if (mw.reg_we && mw.dest != '0 && mw.dest == src) return FWD_MEMWB;
        else                                                    return FWD_REG;
    endfunction

    assign fwd_a = pick(idex.rs, exmem, memwb);
    assign fwd_b = pick(idex.rt, exmem, memwb);

    assign id_rs = ifid.instr[25:21];
    assign id_rt = ifid.instr[20:16];

    // Load data is only ready in MEM, so hold the consumer one cycle
    assign stall = ifid.valid && idex.ctrl.is_load && idex.dest != '0
                   && (idex.dest == id_rs || idex.dest == id_rt);

endmodule

`default_nettype wire

// File: register_file.sv
`default_nettype none

module register_file (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [lapido_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [lapido_pkg::reg_addr_w-1:0] rt_addr,
    output logic [lapido_pkg::xlen-1:0]       rs_data,
    output logic [lapido_pkg::xlen-1:0]       rt_data,
    input  lapido_pkg::memwb_t                wb
);
    import lapido_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    // Write-through so decode sees a value written back this cycle
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr,
                                                  input memwb_t w,
                                                  input logic [xlen-1:0] stored);
        if (addr == '0)                     return '0;
        else if (w.reg_we && w.dest == addr) return w.wb_value;
        else                                 return stored;
    endfunction

    assign rs_data = read_port(rs_addr, wb, regs[rs_addr]);
    assign rt_data = read_port(rt_addr, wb, regs[rt_addr]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) regs[i] <= '0;
        end else if (wb.reg_we && wb.dest != '0) begin
            regs[wb.dest] <= wb.wb_value;
        end
    end

endmodule

`default_nettype wire

// File: id_stage.sv
`default_nettype none

module id_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  lapido_pkg::ifid_t                 ifid,
    input  logic                              stall,
    input  logic                              branch_taken,
    output logic [lapido_pkg::reg_addr_w-1:0] rs_addr,
    output logic [lapido_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [lapido_pkg::xlen-1:0]       rs_data,
    input  logic [lapido_pkg::xlen-1:0]       rt_data,
    output logic                              jump_taken,
    output logic [lapido_pkg::xlen-1:0]       jump_target,
    output lapido_pkg::idex_t                 idex
);
    import lapido_pkg::*;

    opcode_e               op;
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       pc_plus4;
    logic [xlen-1:0]       imm_sext;
    logic [xlen-1:0]       imm;
    logic [jump_w-1:0]     joff;

    // An empty slot decodes as NOP
    assign op = ifid.valid ? opcode_e'(ifid.instr[xlen-1 -: opcode_w]) : OP_NOP;

    assign rs_addr  = ifid.instr[25:21];
    assign rt_addr  = ifid.instr[20:16];
    assign rd       = ifid.instr[15:11];
    assign pc_plus4 = ifid.pc + 32'd4;
    assign imm_sext = {{(xlen-imm_w){ifid.instr[imm_w-1]}}, ifid.instr[imm_w-1:0]};

    // J is PC relative, word offset
    assign joff        = ifid.instr[jump_w-1:0];
    assign jump_taken  = (op == OP_J);
    assign jump_target = pc_plus4 + {{(xlen-jump_w-2){joff[jump_w-1]}}, joff, 2'b00};

    always_comb begin
        ctrl = '0;
        dest = rd;
        imm  = imm_sext;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                ctrl.alu_op = op;
                ctrl.reg_we = 1'b1;
            end
            OP_ADDI: begin
                ctrl.alu_op  = OP_ADD;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                dest         = rt_addr;
            end
            OP_LUI: begin
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = WB_IMM;
                dest        = rt_addr;
                imm         = {ifid.instr[imm_w-1:0], {(xlen-imm_w){1'b0}}};
            end
            OP_LW: begin
                ctrl.alu_op  = OP_ADD;  // Address is rs plus offset
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.wb_sel  = WB_MEM;
                dest         = rt_addr;
            end
            OP_SW: begin
                ctrl.alu_op  = OP_ADD;
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_op    = OP_SUB;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (op == OP_BNE);
            end
            OP_HALT: ctrl.is_halt = 1'b1;
            default: ctrl = '0;  // NOP and J leave no trace past decode
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex <= '0;
        end else if (stall || branch_taken || idex.ctrl.is_halt) begin
            idex <= '0;  // Bubble, nothing issues behind a HALT
        end else begin
            idex.ctrl     <= ctrl;
            idex.pc_plus4 <= pc_plus4;
            idex.rs       <= rs_addr;
            idex.rt       <= rt_addr;
            idex.rs_data  <= rs_data;
            idex.rt_data  <= rt_data;
            idex.dest     <= dest;
            idex.imm      <= imm;
        end
    end

endmodule

`default_nettype wire

// File: if_stage.sv
`default_nettype none

module if_stage #(
    parameter logic [lapido_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        stall,
    input  logic                        jump_taken,
    input  logic [lapido_pkg::xlen-1:0] jump_target,
    input  logic                        branch_taken,
    input  logic [lapido_pkg::xlen-1:0] branch_target,
    input  logic                        halt,
    output logic [lapido_pkg::xlen-1:0] imem_addr,
    input  logic [lapido_pkg::xlen-1:0] imem_data,
    output lapido_pkg::ifid_t           ifid
);
    import lapido_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic            frozen;  // Set once a HALT has left decode
    logic            freeze;

    assign freeze    = frozen | halt;
    assign imem_addr = pc;

    // Branch is the older instruction, so it beats a jump
    always_comb begin
        if (branch_taken)         pc_next = branch_target;
        else if (jump_taken)      pc_next = jump_target;
        else if (stall || freeze) pc_next = pc;
        else                      pc_next = pc + 32'd4;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= RESET_PC;
            frozen <= 1'b0;
            ifid   <= '0;
        end else begin
            pc <= pc_next;
            if (halt) frozen <= 1'b1;
            if (branch_taken || jump_taken || freeze) begin
                ifid.valid <= 1'b0;  // Drop the slot fetched this cycle
            end else if (!stall) begin
                ifid.valid <= 1'b1;
                ifid.pc    <= pc;
                ifid.instr <= imem_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: lapido_pkg.sv
`default_nettype none

package lapido_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 6;
    localparam int imm_w      = 16;  // I-type immediate
    localparam int jump_w     = 26;  // J offset, counted in words

    // Opcode sits in instr[31:26]; each R-type op has its own code
    typedef enum logic [opcode_w-1:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SLT  = 6'd6,
        OP_ADDI = 6'd7,
        OP_LUI  = 6'd8,
        OP_LW   = 6'd9,
        OP_SW   = 6'd10,
        OP_BEQ  = 6'd11,
        OP_BNE  = 6'd12,
        OP_J    = 6'd13,
        OP_HALT = 6'd14
    } opcode_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_IMM = 2'd2
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

    // All-zero value is a bubble
    typedef struct packed {
        opcode_e alu_op;
        logic    use_imm;
        logic    reg_we;
        logic    mem_we;
        logic    is_load;
        logic    is_branch;
        logic    branch_ne;
        wb_sel_e wb_sel;
        logic    is_halt;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [xlen-1:0]       rs_data;
        logic [xlen-1:0]       rt_data;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       imm;
    } idex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       alu_res;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       branch_target;
    } exmem_t;

    typedef struct packed {
        logic                  reg_we;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       wb_value;
    } memwb_t;

endpackage

`default_nettype wire
